// ==== common/csrPkg.sv ====
package csrPkg;

    localparam int ADDR_WIDTH = 5;
    localparam int DATA_WIDTH = 32;
    localparam int NUM_LANES = 4;
    localparam int NUM_COUNTERS = 4;
    localparam int CNT_IDX_WIDTH = $clog2(NUM_COUNTERS);

    // counter slots
    localparam int CNT_COMMIT = 0;
    localparam int CNT_BRANCH = 1;
    localparam int CNT_MISPRED = 2;
    localparam int CNT_WB = 3;

    typedef enum logic [ADDR_WIDTH-1:0] {
        REG_MODE       = 0,
        REG_IRQ_VEC    = 1,
        REG_TMR_CMP    = 2,
        REG_TMR_CTRL   = 3,
        REG_TMR_VAL    = 4,
        REG_IRQ_STATUS = 5,
        REG_CNT_EN     = 6,
        REG_CNT_BASE   = 8
    } regAddr_e;

    typedef struct packed {
        logic [29:0] reserved;
        logic noBrk;
        logic noExt;
    } modeFlags_t;

    typedef struct packed {
        logic [NUM_LANES-1:0] comValid;
        logic [NUM_LANES-1:0] comBranch;
        logic mispred;
        logic [NUM_LANES-1:0] wbValid;
    } coreEvents_t;

    typedef struct packed {
        logic enable;
        logic autoReload;
        logic irqEnable;
        logic [DATA_WIDTH-1:0] compare;
        logic clearValue;
        logic clearPending;
    } tmrCfg_t;

    typedef struct packed {
        logic [NUM_COUNTERS-1:0] enable;
        logic [NUM_COUNTERS-1:0] clear;
    } cntCfg_t;

    // two words per counter, low word first
    function automatic logic isCntAddr(logic [ADDR_WIDTH-1:0] addr);
        return (addr >= REG_CNT_BASE) && (addr < REG_CNT_BASE + 2 * NUM_COUNTERS);
    endfunction

    function automatic logic [CNT_IDX_WIDTH-1:0] cntIndex(logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] offset;
        offset = addr - REG_CNT_BASE;
        return offset[CNT_IDX_WIDTH:1];
    endfunction

endpackage

// ==== coreCsr.f ====
common/csrPkg.sv
csr/csrRegs.sv
perf/eventCounters.sv
timer/irqTimer.sv
verilog/coreCsr.sv
test/coreCsr_chk.sv
test/coreCsrTb.sv

// ==== csr/csrRegs.sv ====
`timescale 1ns/1ps

module csrRegs import csrPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic clk,
    input  logic rst,

    input  logic we,
    input  logic [3:0] writeMask,
    input  logic [ADDR_WIDTH-1:0] writeAddr,
    input  logic [DATA_WIDTH-1:0] writeData,

    input  logic re,
    input  logic [ADDR_WIDTH-1:0] readAddr,
    output logic [DATA_WIDTH-1:0] readData,
    output logic readValid,

    input  logic [NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts,
    input  logic [DATA_WIDTH-1:0] tmrValue,
    input  logic tmrPending,

    output modeFlags_t mode,
    output logic [DATA_WIDTH-1:0] irqVector,
    output tmrCfg_t tmrCfg,
    output cntCfg_t cntCfg
);

    typedef struct packed {
        logic irqEnable;
        logic autoReload;
        logic enable;
    } tmrCtrl_t;

    localparam int CTRL_BITS = $bits(tmrCtrl_t);

    modeFlags_t modeReg;
    logic [DATA_WIDTH-1:0] irqVecReg;
    logic [DATA_WIDTH-1:0] tmrCmpReg;
    tmrCtrl_t tmrCtrlReg;
    logic [NUM_COUNTERS-1:0] cntEnReg;

    logic clrValue;
    logic clrPending;
    logic [NUM_COUNTERS-1:0] cntClear;

    logic [COUNTER_WIDTH-1:0] selCount;
    logic [DATA_WIDTH-1:0] readMux;

    // byte lanes with mask set take the new data
    function automatic logic [DATA_WIDTH-1:0] maskMerge(
        logic [DATA_WIDTH-1:0] oldVal,
        logic [DATA_WIDTH-1:0] newVal,
        logic [3:0] mask
    );
        logic [DATA_WIDTH-1:0] result;
        result = oldVal;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[b*8 +: 8] = newVal[b*8 +: 8];
            end
        end
        return result;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            modeReg <= '0;
            irqVecReg <= '0;
            tmrCmpReg <= '0;
            tmrCtrlReg <= '0;
            cntEnReg <= '0;
        end else if (we) begin
            case (writeAddr)
                REG_MODE: modeReg <= maskMerge(modeReg, writeData, writeMask);
                REG_IRQ_VEC: irqVecReg <= maskMerge(irqVecReg, writeData, writeMask);
                REG_TMR_CMP: tmrCmpReg <= maskMerge(tmrCmpReg, writeData, writeMask);
                REG_TMR_CTRL: tmrCtrlReg <= tmrCtrl_t'(CTRL_BITS'(
                    maskMerge(DATA_WIDTH'(tmrCtrlReg), writeData, writeMask)));
                REG_CNT_EN: cntEnReg <= NUM_COUNTERS'(
                    maskMerge(DATA_WIDTH'(cntEnReg), writeData, writeMask));
                default: ;
            endcase
        end
    end

    // clears go out one cycle after the write edge
    always_ff @(posedge clk) begin
        if (rst) begin
            clrValue <= 1'b0;
            clrPending <= 1'b0;
            cntClear <= '0;
        end else begin
            clrValue <= we && (writeAddr == REG_TMR_VAL);
            clrPending <= we && (writeAddr == REG_IRQ_STATUS) && writeMask[0] && writeData[0];
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                cntClear[i] <= we && isCntAddr(writeAddr) && (cntIndex(writeAddr) == i);
            end
        end
    end

    assign selCount = counts[cntIndex(readAddr)];

    always_comb begin
        readMux = '0;
        case (readAddr)
            REG_MODE: readMux = modeReg;
            REG_IRQ_VEC: readMux = irqVecReg;
            REG_TMR_CMP: readMux = tmrCmpReg;
            REG_TMR_CTRL: readMux = DATA_WIDTH'(tmrCtrlReg);
            REG_TMR_VAL: readMux = tmrValue;
            REG_IRQ_STATUS: readMux = DATA_WIDTH'(tmrPending);
            REG_CNT_EN: readMux = DATA_WIDTH'(cntEnReg);
            default: begin
                // odd address is the high word
                if (isCntAddr(readAddr)) begin
                    readMux = readAddr[0] ? DATA_WIDTH'(selCount >> DATA_WIDTH)
                                          : selCount[DATA_WIDTH-1:0];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readValid <= 1'b0;
        end else begin
            readValid <= re;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            readData <= readMux;
        end
    end

    assign mode = modeReg;
    assign irqVector = irqVecReg;

    always_comb begin
        tmrCfg.enable = tmrCtrlReg.enable;
        tmrCfg.autoReload = tmrCtrlReg.autoReload;
        tmrCfg.irqEnable = tmrCtrlReg.irqEnable;
        tmrCfg.compare = tmrCmpReg;
        tmrCfg.clearValue = clrValue;
        tmrCfg.clearPending = clrPending;
    end

    assign cntCfg.enable = cntEnReg;
    assign cntCfg.clear = cntClear;

endmodule

// ==== perf/eventCounters.sv ====
`timescale 1ns/1ps

module eventCounters import csrPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic clk,
    input  logic rst,
    input  coreEvents_t events,
    input  cntCfg_t cntCfg,
    output logic [NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts
);

    localparam int INC_WIDTH = $clog2(NUM_LANES + 1);

    logic [NUM_COUNTERS-1:0][INC_WIDTH-1:0] incr;
    logic [NUM_COUNTERS-1:0][INC_WIDTH-1:0] gatedIncr;
    logic [NUM_LANES-1:0] branchLanes;

    function automatic logic [INC_WIDTH-1:0] popCount(logic [NUM_LANES-1:0] lanes);
        logic [INC_WIDTH-1:0] sum;
        sum = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            sum = sum + INC_WIDTH'(lanes[l]);
        end
        return sum;
    endfunction

    // a branch only counts on a lane that actually committed
    assign branchLanes = events.comValid & events.comBranch;

    always_comb begin
        incr = '0;
        incr[CNT_COMMIT] = popCount(events.comValid);
        incr[CNT_BRANCH] = popCount(branchLanes);
        incr[CNT_MISPRED] = INC_WIDTH'(events.mispred);
        incr[CNT_WB] = popCount(events.wbValid);
    end

    // disabled counters see a zero step
    always_comb begin
        for (int c = 0; c < NUM_COUNTERS; c++) begin
            gatedIncr[c] = cntCfg.enable[c] ? incr[c] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            for (int c = 0; c < NUM_COUNTERS; c++) begin
                // clear beats the increment of the same cycle
                if (cntCfg.clear[c]) begin
                    counts[c] <= '0;
                end else begin
                    counts[c] <= counts[c] + COUNTER_WIDTH'(gatedIncr[c]);
                end
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run the regression, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary -j 0 --assert -Wno-fatal --top-module coreCsrTb \
    -Mdir obj_dir -f coreCsr.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/VcoreCsrTb > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

// ==== test/coreCsrTb.sv ====
`timescale 1ns/1ps

module coreCsrTb import csrPkg::*; ();

    localparam int CYCLE_LIMIT = 20000;
    localparam int EV_BITS = $bits(coreEvents_t);

    typedef struct packed {
        logic check;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } readReq_t;

    logic clk = 1'b0;
    logic rst;
    logic we;
    logic re;
    logic [3:0] writeMask;
    logic [ADDR_WIDTH-1:0] writeAddr;
    logic [ADDR_WIDTH-1:0] readAddr;
    logic [DATA_WIDTH-1:0] writeData;
    logic [DATA_WIDTH-1:0] readData;
    logic [DATA_WIDTH-1:0] irqVector;
    logic readValid;
    logic tmrIrq;
    coreEvents_t events;
    modeFlags_t mode;

    readReq_t expQ[$];
    readReq_t monReq;
    logic [63:0] modelCnt[NUM_COUNTERS];
    logic [DATA_WIDTH-1:0] shadow[8];
    int cycleCount = 0;
    int errCount = 0;
    int passCount = 0;
    int failCount = 0;

    coreCsr #(.COUNTER_WIDTH(64)) i_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    function automatic logic [63:0] expIncr(coreEvents_t ev, int idx);
        case (idx)
            CNT_COMMIT: return 64'($countones(ev.comValid));
            CNT_BRANCH: return 64'($countones(ev.comValid & ev.comBranch));
            CNT_MISPRED: return 64'(ev.mispred);
            default: return 64'($countones(ev.wbValid));
        endcase
    endfunction

    // value after n enabled edges counted from a cleared timer
    function automatic logic [31:0] expTimerValue(int n, int cmp, logic reload);
        if (reload) return 32'(n % (cmp + 1));
        return 32'((n < cmp) ? n : cmp);
    endfunction

    function automatic logic expTimerPending(int n, int cmp);
        return n > cmp;
    endfunction

    function automatic logic [31:0] mergeBytes(logic [31:0] oldVal, logic [31:0] newVal,
                                               logic [3:0] mask);
        logic [31:0] byteMask;
        byteMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (oldVal & ~byteMask) | (newVal & byteMask);
    endfunction

    function automatic logic [31:0] storedBits(int addr);
        case (addr)
            REG_TMR_CTRL: return 32'h7;
            REG_CNT_EN: return 32'hF;
            default: return '1;
        endcase
    endfunction

    task automatic busWrite(int addr, logic [31:0] data, logic [3:0] mask);
        we = 1'b1;
        writeAddr = ADDR_WIDTH'(addr);
        writeData = data;
        writeMask = mask;
        @(posedge clk);
        #1;
        we = 1'b0;
    endtask

    task automatic busRead(int addr, logic [31:0] exp, logic check, output logic [31:0] got);
        readReq_t req;
        int waited;
        waited = 0;
        req.check = check;
        req.addr = ADDR_WIDTH'(addr);
        req.data = exp;
        expQ.push_back(req);
        re = 1'b1;
        readAddr = ADDR_WIDTH'(addr);
        @(posedge clk);
        #1;
        re = 1'b0;
        while (!readValid && waited < 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!readValid) begin
            $display("read of address %0d got no response", addr);
            errCount++;
        end
        got = readData;
    endtask

    task automatic readCheck(int addr, logic [31:0] exp);
        logic [31:0] got;
        busRead(addr, exp, 1'b1, got);
    endtask

    task automatic checkEq(string what, logic [63:0] got, logic [63:0] exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic checkCounters();
        for (int c = 0; c < NUM_COUNTERS; c++) begin
            readCheck(REG_CNT_BASE + 2 * c, modelCnt[c][31:0]);
            readCheck(REG_CNT_BASE + 2 * c + 1, modelCnt[c][63:32]);
        end
    endtask

    task automatic runEvents(int cycles, logic [3:0] enMask);
        logic [31:0] r;
        coreEvents_t ev;
        for (int n = 0; n < cycles; n++) begin
            r = $urandom;
            ev = r[EV_BITS-1:0];
            events = ev;
            for (int c = 0; c < NUM_COUNTERS; c++) begin
                if (enMask[c]) modelCnt[c] += expIncr(ev, c);
            end
            @(posedge clk);
            #1;
        end
        events = '0;
    endtask

    task automatic waitIrq(int limit);
        int n;
        n = 0;
        while (!tmrIrq && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!tmrIrq) begin
            $display("tmrIrq did not rise within %0d cycles", limit);
            errCount++;
        end
    endtask

    task automatic finishTest(string name, int errsBefore);
        if (errCount == errsBefore) begin
            passCount++;
            $display("test %s: pass", name);
        end else begin
            failCount++;
            $display("test %s: FAIL with %0d errors", name, errCount - errsBefore);
        end
    endtask

    // every returned read is matched against the request queued when it was issued
    always @(negedge clk) begin
        if (!rst && readValid) begin
            if (expQ.size() == 0) begin
                $display("read data returned at %0t with no request outstanding", $time);
                errCount++;
            end else begin
                monReq = expQ.pop_front();
                if (monReq.check) begin
                    assert (readData == monReq.data) else begin
                        $display("Mismatch at %0t: address %0d read %h expected %h",
                                 $time, monReq.addr, readData, monReq.data);
                        errCount++;
                    end
                end
            end
        end
    end

    initial begin
        wait (cycleCount >= CYCLE_LIMIT);
        $display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
        $display("Regression failed");
        $finish;
    end

    initial begin
        logic [31:0] got;
        logic [31:0] data;
        logic [3:0] mask;
        logic [3:0] enMask;
        int addr;
        int errs;
        int k;
        int t0;
        int lim;
        void'($urandom(3081));
        rst = 1'b1;
        we = 1'b0;
        re = 1'b0;
        writeMask = '0;
        writeAddr = '0;
        readAddr = '0;
        writeData = '0;
        events = '0;
        foreach (shadow[i]) shadow[i] = '0;
        foreach (modelCnt[i]) modelCnt[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = errCount;
        checkEq("readValid after reset", readValid, 0);
        checkEq("tmrIrq after reset", tmrIrq, 0);
        checkEq("mode after reset", mode, 0);
        checkEq("irqVector after reset", irqVector, 0);
        for (int a = 0; a < 32; a++) readCheck(a, 32'h0);
        for (int n = 0; n < 40; n++) begin
            case ($urandom % 5)
                0: addr = REG_MODE;
                1: addr = REG_IRQ_VEC;
                2: addr = REG_TMR_CMP;
                3: addr = REG_TMR_CTRL;
                default: addr = REG_CNT_EN;
            endcase
            data = $urandom;
            mask = 4'($urandom);
            shadow[addr] = mergeBytes(shadow[addr], data, mask) & storedBits(addr);
            busWrite(addr, data, mask);
            readCheck(addr, shadow[addr]);
            checkEq("mode output", mode, shadow[REG_MODE]);
            checkEq("irqVector output", irqVector, shadow[REG_IRQ_VEC]);
        end
        busWrite(7, $urandom, 4'hF);
        for (int a = 16; a < 32; a++) busWrite(a, $urandom, 4'hF);
        readCheck(7, 32'h0);
        for (int a = 16; a < 32; a++) readCheck(a, 32'h0);
        finishTest("reset and readback", errs);

        errs = errCount;
        busWrite(REG_CNT_EN, 32'hF, 4'hF);
        for (int c = 0; c < NUM_COUNTERS; c++) begin
            busWrite(REG_CNT_BASE + 2 * c, 32'h0, 4'hF);
            modelCnt[c] = '0;
        end
        idle(2);
        runEvents(1000, 4'hF);
        idle(2);
        checkCounters();
        finishTest("event counting", errs);

        errs = errCount;
        for (int round = 0; round < 3; round++) begin
            enMask = 4'($urandom);
            busWrite(REG_CNT_EN, 32'(enMask), 4'h1);
            runEvents(300, enMask);
            idle(2);
            checkCounters();
            k = $urandom % NUM_COUNTERS;
            busWrite(REG_CNT_BASE + 2 * k + ($urandom % 2), $urandom, 4'hF);
            modelCnt[k] = '0;
            idle(2);
            checkCounters();
        end
        finishTest("enable mask and clear", errs);

        errs = errCount;
        busWrite(REG_TMR_CTRL, 32'h0, 4'hF);
        busWrite(REG_TMR_CMP, 32'd50, 4'hF);
        busWrite(REG_TMR_VAL, 32'h0, 4'hF);
        busWrite(REG_IRQ_STATUS, 32'h1, 4'hF);
        idle(1);
        busWrite(REG_TMR_CTRL, 32'h5, 4'hF);
        t0 = cycleCount;
        waitIrq(200);
        readCheck(REG_TMR_VAL, expTimerValue(cycleCount - t0, 50, 1'b0));
        readCheck(REG_IRQ_STATUS, 32'(expTimerPending(cycleCount - t0, 50)));
        idle(5);
        readCheck(REG_TMR_VAL, 32'd50);
        busWrite(REG_IRQ_STATUS, 32'h1, 4'h1);
        idle(1);
        readCheck(REG_IRQ_STATUS, 32'h0);
        checkEq("tmrIrq after status clear", tmrIrq, 0);
        // interrupt gated off, pending still expected
        busWrite(REG_TMR_CTRL, 32'h1, 4'hF);
        busWrite(REG_TMR_VAL, 32'h0, 4'hF);
        lim = 0;
        do begin
            busRead(REG_IRQ_STATUS, 32'h0, 1'b0, got);
            checkEq("tmrIrq with irqEnable clear", tmrIrq, 0);
            lim++;
        end while (got != 32'h1 && lim < 200);
        checkEq("pending with irqEnable clear", got, 1);
        finishTest("timer compare and interrupt", errs);

        errs = errCount;
        busWrite(REG_TMR_CTRL, 32'h0, 4'hF);
        busWrite(REG_TMR_CMP, 32'd20, 4'hF);
        busWrite(REG_TMR_VAL, 32'h0, 4'hF);
        busWrite(REG_IRQ_STATUS, 32'h1, 4'hF);
        idle(1);
        busWrite(REG_TMR_CTRL, 32'h3, 4'hF);
        t0 = cycleCount;
        // reload on every hit keeps the value within 0 to 20
        for (int n = 0; n < 60; n++) begin
            readCheck(REG_TMR_VAL, expTimerValue(cycleCount - t0, 20, 1'b1));
        end
        readCheck(REG_IRQ_STATUS, 32'(expTimerPending(cycleCount - t0, 20)));
        busWrite(REG_TMR_VAL, 32'h0, 4'hF);
        t0 = cycleCount;
        idle(1 + $urandom % 10);
        busRead(REG_TMR_VAL, 32'h0, 1'b0, got);
        assert (got <= cycleCount - t0) else begin
            $display("Mismatch at %0t: timer value %0d after restart, only %0d cycles passed",
                     $time, got, cycleCount - t0);
            errCount++;
        end
        finishTest("auto reload", errs);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== test/coreCsr_chk.sv ====
`timescale 1ns/1ps

module coreCsrChk import csrPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input logic clk,
    input logic rst,
    input logic re,
    input logic readValid,
    input logic tmrPending,
    input tmrCfg_t tmrCfg,
    input cntCfg_t cntCfg,
    input logic [NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts
);

    // one-cycle read latency, never early and never dropped
    readLatency: assert property (@(posedge clk) disable iff (rst) readValid == $past(re))
        else $error("readValid does not follow re by one cycle");

    // pending is sticky until a clear pulse
    pendingSticky: assert property (@(posedge clk) disable iff (rst)
        $fell(tmrPending) |-> $past(tmrCfg.clearPending))
        else $error("timer pending dropped without a clear pulse");

    for (genvar c = 0; c < NUM_COUNTERS; c++) begin : monoCheck
        noDecrease: assert property (@(posedge clk) disable iff (rst)
            (counts[c] >= $past(counts[c])) || $past(cntCfg.clear[c]))
            else $error("counter %0d went down without a clear", c);
    end

endmodule

bind coreCsr coreCsrChk #(
    .COUNTER_WIDTH(COUNTER_WIDTH)
) i_chk (
    .clk(clk),
    .rst(rst),
    .re(re),
    .readValid(readValid),
    .tmrPending(tmrPending),
    .tmrCfg(tmrCfg),
    .cntCfg(cntCfg),
    .counts(counts)
);

// ==== timer/irqTimer.sv ====
`timescale 1ns/1ps

module irqTimer import csrPkg::*; (
    input  logic clk,
    input  logic rst,
    input  tmrCfg_t tmrCfg,
    output logic [DATA_WIDTH-1:0] value,
    output logic pending,
    output logic tmrIrq
);

    logic hit;
    logic held;

    // one hit per arrival at compare, not one per cycle spent there
    assign hit = tmrCfg.enable && !held && (value == tmrCfg.compare);

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
            held <= 1'b0;
        end else if (tmrCfg.clearValue) begin
            value <= '0;
            held <= 1'b0;
        end else if (hit) begin
            value <= tmrCfg.autoReload ? '0 : value;
            held <= !tmrCfg.autoReload;
        end else if (held) begin
            // new compare value lets the count run on
            held <= (value == tmrCfg.compare);
        end else if (tmrCfg.enable) begin
            value <= value + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (hit) begin
            pending <= 1'b1;
        end else if (tmrCfg.clearPending) begin
            pending <= 1'b0;
        end
    end

    assign tmrIrq = pending && tmrCfg.irqEnable;

endmodule

// ==== verilog/coreCsr.sv ====
`timescale 1ns/1ps

module coreCsr import csrPkg::*; #(
    parameter int COUNTER_WIDTH = 64
) (
    input  logic clk,
    input  logic rst,

    input  logic we,
    input  logic [3:0] writeMask,
    input  logic [ADDR_WIDTH-1:0] writeAddr,
    input  logic [DATA_WIDTH-1:0] writeData,

    input  logic re,
    input  logic [ADDR_WIDTH-1:0] readAddr,
    output logic [DATA_WIDTH-1:0] readData,
    output logic readValid,

    input  coreEvents_t events,

    output modeFlags_t mode,
    output logic [DATA_WIDTH-1:0] irqVector,
    output logic tmrIrq
);

    cntCfg_t cntCfg;
    tmrCfg_t tmrCfg;
    logic [NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counts;
    logic [DATA_WIDTH-1:0] tmrValue;
    logic tmrPending;

    csrRegs #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_regs (
        .clk(clk),
        .rst(rst),
        .we(we),
        .writeMask(writeMask),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .re(re),
        .readAddr(readAddr),
        .readData(readData),
        .readValid(readValid),
        .counts(counts),
        .tmrValue(tmrValue),
        .tmrPending(tmrPending),
        .mode(mode),
        .irqVector(irqVector),
        .tmrCfg(tmrCfg),
        .cntCfg(cntCfg)
    );

    eventCounters #(
        .COUNTER_WIDTH(COUNTER_WIDTH)
    ) i_counters (
        .clk(clk),
        .rst(rst),
        .events(events),
        .cntCfg(cntCfg),
        .counts(counts)
    );

    irqTimer i_timer (
        .clk(clk),
        .rst(rst),
        .tmrCfg(tmrCfg),
        .value(tmrValue),
        .pending(tmrPending),
        .tmrIrq(tmrIrq)
    );

endmodule
